//--- hw/ahbMatrix_config.svh
`ifndef AHB_MATRIX_CONFIG_SVH
`define AHB_MATRIX_CONFIG_SVH

// bus widths
`define AHB_ADDR_WIDTH      32
`define AHB_DATA_WIDTH      32

`define AHB_DEVICE_COUNT    2       // RAM and GPIO

// ----------------------------------------
// address windows on physical address bits
// ----------------------------------------

// RAM, 64 MB at 0x0000_0000, matched on bits 28..26
`define RAM_ADDR_MATCH      3'h0

// GPIO, 4 MB at 0x1F80_0000, matched on bits 28..22
`define GPIO_ADDR_MATCH     7'h7e

// ----------------------------------------
// subordinate sizes
// ----------------------------------------
`define RAM_ADDR_WIDTH      10      // 1024 words, repeats inside the window

`define GPIO_N_RED_LEDS     18
`define GPIO_N_GREEN_LEDS   8
`define GPIO_N_SWITCHES     18
`define GPIO_N_BUTTONS      4
`define GPIO_HEX_WIDTH      32      // eight digits of four bits

`endif

//--- hw/ahbPkg.sv
`include "ahbMatrix_config.svh"

package ahbPkg;

    typedef logic [`AHB_ADDR_WIDTH-1:0] addrT;
    typedef logic [`AHB_DATA_WIDTH-1:0] dataT;

    // HTRANS encoding
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htransT;

    // HSIZE, only up to the bus width
    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsizeT;

    typedef enum logic {
        OKAY  = 1'b0,
        ERROR = 1'b1
    } hrespT;

    // ----------------------------------------
    // pipeline stages and subordinate response
    // ----------------------------------------
    typedef struct packed {
        addrT   addr;
        htransT trans;
        hsizeT  size;
        logic   write;
    } ahbAddrPhaseT;

    typedef struct packed {
        logic                      valid;     // accepted transfer in data phase
        logic                      write;
        logic [`AHB_ADDR_WIDTH-3:0] wordAddr;
        logic [3:0]                byteMask;  // lane 0 holds the lowest address
    } ahbDataPhaseT;

    typedef struct packed {
        dataT  rdata;
        logic  readyOut;
        hrespT resp;
    } ahbRespT;

endpackage

//--- hw/memMapPkg.sv
`include "ahbMatrix_config.svh"

package memMapPkg;

    localparam int DEV_IDX_W = $clog2(`AHB_DEVICE_COUNT);

    // bit position of each subordinate in the select vector
    typedef enum logic [DEV_IDX_W-1:0] {
        DEV_RAM  = 0,
        DEV_GPIO = 1
    } devIdxT;

    typedef logic [`AHB_DEVICE_COUNT-1:0] devSelT;   // one-hot, zero means unmapped

    // ----------------------------------------
    // GPIO pins
    // ----------------------------------------
    typedef struct packed {
        logic [`GPIO_N_SWITCHES-1:0] switches;
        logic [`GPIO_N_BUTTONS-1:0]  buttons;
    } gpioInT;

    typedef struct packed {
        logic [`GPIO_N_RED_LEDS-1:0]   redLeds;
        logic [`GPIO_N_GREEN_LEDS-1:0] greenLeds;
        logic [`GPIO_HEX_WIDTH-1:0]    hex;
    } gpioOutT;

    // register word offsets inside the GPIO window
    localparam int GPIO_REG_W = 3;

    localparam logic [GPIO_REG_W-1:0] REG_RED      = 3'd0;
    localparam logic [GPIO_REG_W-1:0] REG_GREEN    = 3'd1;
    localparam logic [GPIO_REG_W-1:0] REG_HEX      = 3'd2;
    localparam logic [GPIO_REG_W-1:0] REG_SWITCHES = 3'd3;
    localparam logic [GPIO_REG_W-1:0] REG_BUTTONS  = 3'd4;

endpackage

//--- hw/ahbSlavePort.sv
`timescale 1ns/10ps

`include "ahbMatrix_config.svh"

module ahbSlavePort
    import ahbPkg::*;
(
    input  logic         HCLK,
    input  logic         HRESETn,
    input  ahbAddrPhaseT addrPhase,
    input  logic         sel,
    input  logic         HREADY,
    output ahbDataPhaseT dataPhase
);

    logic       active;
    logic       accept;
    logic [3:0] byteMask;

    // BUSY and IDLE carry no data phase
    assign active = (addrPhase.trans == NONSEQ) || (addrPhase.trans == SEQ);
    assign accept = sel && active && HREADY;

    // ----------------------------------------
    // little-endian lane enables
    // ----------------------------------------
    always_comb begin
        case (addrPhase.size)
            BYTE:    byteMask = 4'b0001 << addrPhase.addr[1:0];
            HALF:    byteMask = addrPhase.addr[1] ? 4'b1100 : 4'b0011;
            default: byteMask = 4'b1111;   // word, wider sizes not supported
        endcase
    end

    // ----------------------------------------
    // data-phase register
    // ----------------------------------------

    // holds while HREADY is low, so the subordinate sees a stable transfer
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            dataPhase <= '0;
        end else if (HREADY) begin
            dataPhase.valid <= accept;
            if (accept) begin
                dataPhase.write    <= addrPhase.write;
                dataPhase.wordAddr <= addrPhase.addr[`AHB_ADDR_WIDTH-1:2];
                dataPhase.byteMask <= byteMask;
            end
        end
    end

endmodule

//--- hw/ahbInterconnect.sv
`timescale 1ns/10ps

`include "ahbMatrix_config.svh"

module ahbInterconnect
    import ahbPkg::*;
    import memMapPkg::*;
(
    input  logic         HCLK,
    input  logic         HRESETn,
    input  ahbAddrPhaseT addrPhase,
    output devSelT       sel,
    input  ahbRespT      ramResp,
    input  ahbRespT      gpioResp,
    output logic         HREADY,
    output dataT         HRDATA,
    output hrespT        HRESP
);

    devSelT dataSel;   // owner of the transfer now in data phase

    // ----------------------------------------
    // address decode
    // ----------------------------------------

    // the upper three bits are the segment, so kseg0/kseg1 alias to physical
    always_comb begin
        sel = '0;
        sel[DEV_RAM]  = (addrPhase.addr[28:26] == `RAM_ADDR_MATCH);
        sel[DEV_GPIO] = (addrPhase.addr[28:22] == `GPIO_ADDR_MATCH);
    end

    // ----------------------------------------
    // data-phase select
    // ----------------------------------------

    // advances only when the current data phase completes
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            dataSel <= '0;
        end else if (HREADY) begin
            dataSel <= sel;
        end
    end

    // any subordinate may stretch the shared data phase
    assign HREADY = ramResp.readyOut & gpioResp.readyOut;

    // ----------------------------------------
    // response multiplexer
    // ----------------------------------------
    always_comb begin
        if (dataSel[DEV_RAM]) begin
            HRDATA = ramResp.rdata;
            HRESP  = ramResp.resp;
        end else if (dataSel[DEV_GPIO]) begin
            HRDATA = gpioResp.rdata;
            HRESP  = gpioResp.resp;
        end else begin
            // unmapped: reads as zero, never an error
            HRDATA = '0;
            HRESP  = OKAY;
        end
    end

endmodule

//--- hw/ahbRam.sv
`timescale 1ns/10ps

`include "ahbMatrix_config.svh"

module ahbRam
    import ahbPkg::*;
(
    input  logic         HCLK,
    input  logic         HRESETn,
    input  ahbAddrPhaseT addrPhase,
    input  logic         sel,
    input  logic         HREADY,
    input  dataT         HWDATA,
    output ahbRespT      resp
);

    localparam int RAM_WORDS = 1 << `RAM_ADDR_WIDTH;

    ahbDataPhaseT               dataPhase;
    dataT                       mem [RAM_WORDS];
    dataT                       rdataReg;
    logic [`RAM_ADDR_WIDTH-1:0] wordIdx;
    logic                       waitFlag;     // set during the read wait cycle
    logic                       readPending;
    logic                       writeNow;

    ahbSlavePort port (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .addrPhase (addrPhase),
        .sel       (sel),
        .HREADY    (HREADY),
        .dataPhase (dataPhase)
    );

    assign wordIdx = dataPhase.wordAddr[`RAM_ADDR_WIDTH-1:0];   // upper bits alias

    // first cycle of a read data phase, array output not yet registered
    assign readPending = dataPhase.valid && !dataPhase.write && !waitFlag;

    // HWDATA is valid on the edge that closes the write data phase
    assign writeNow = dataPhase.valid && dataPhase.write && HREADY;

    // ----------------------------------------
    // read wait state
    // ----------------------------------------
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            waitFlag <= 1'b0;
        end else begin
            waitFlag <= readPending;   // high for exactly one cycle per read
        end
    end

    // ----------------------------------------
    // array
    // ----------------------------------------
    always_ff @(posedge HCLK) begin
        if (writeNow) begin
            for (int i = 0; i < 4; i++) begin
                if (dataPhase.byteMask[i]) begin
                    mem[wordIdx][i*8 +: 8] <= HWDATA[i*8 +: 8];
                end
            end
        end
        if (readPending) begin
            rdataReg <= mem[wordIdx];
        end
    end

    assign resp = '{rdata: rdataReg, readyOut: !readPending, resp: OKAY};

endmodule

//--- hw/ahbGpio.sv
`timescale 1ns/10ps

`include "ahbMatrix_config.svh"

module ahbGpio
    import ahbPkg::*;
    import memMapPkg::*;
(
    input  logic         HCLK,
    input  logic         HRESETn,
    input  ahbAddrPhaseT addrPhase,
    input  logic         sel,
    input  logic         HREADY,
    input  dataT         HWDATA,
    input  gpioInT       ioIn,
    output gpioOutT      ioOut,
    output ahbRespT      resp
);

    ahbDataPhaseT          dataPhase;
    gpioOutT               outReg;
    gpioInT                inMeta;      // first synchroniser stage
    gpioInT                inSync;
    logic [GPIO_REG_W-1:0] regOfs;
    logic                  writeNow;
    dataT                  laneMask;
    dataT                  redNext;
    dataT                  greenNext;
    dataT                  hexNext;
    dataT                  rdataMux;

    ahbSlavePort port (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .addrPhase (addrPhase),
        .sel       (sel),
        .HREADY    (HREADY),
        .dataPhase (dataPhase)
    );

    assign regOfs   = dataPhase.wordAddr[GPIO_REG_W-1:0];
    assign writeNow = dataPhase.valid && dataPhase.write && HREADY;

    // merge written lanes into the current register value
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            laneMask[i*8 +: 8] = {8{dataPhase.byteMask[i]}};
        end
        redNext   = (dataT'(outReg.redLeds) & ~laneMask) | (HWDATA & laneMask);
        greenNext = (dataT'(outReg.greenLeds) & ~laneMask) | (HWDATA & laneMask);
        hexNext   = (dataT'(outReg.hex) & ~laneMask) | (HWDATA & laneMask);
    end

    // ----------------------------------------
    // output registers and input sync
    // ----------------------------------------
    always_ff @(posedge HCLK) begin
        if (!HRESETn) begin
            outReg <= '0;
            inMeta <= '0;
            inSync <= '0;
        end else begin
            inMeta <= ioIn;
            inSync <= inMeta;
            if (writeNow) begin
                case (regOfs)   // switches, buttons and unknown offsets drop the write
                    REG_RED:   outReg.redLeds   <= redNext[`GPIO_N_RED_LEDS-1:0];
                    REG_GREEN: outReg.greenLeds <= greenNext[`GPIO_N_GREEN_LEDS-1:0];
                    REG_HEX:   outReg.hex       <= hexNext[`GPIO_HEX_WIDTH-1:0];
                    default:   ;
                endcase
            end
        end
    end

    // word read-back, zero for unknown offsets
    always_comb begin
        case (regOfs)
            REG_RED:      rdataMux = dataT'(outReg.redLeds);
            REG_GREEN:    rdataMux = dataT'(outReg.greenLeds);
            REG_HEX:      rdataMux = dataT'(outReg.hex);
            REG_SWITCHES: rdataMux = dataT'(inSync.switches);
            REG_BUTTONS:  rdataMux = dataT'(inSync.buttons);
            default:      rdataMux = '0;
        endcase
    end

    assign ioOut = outReg;
    assign resp  = '{rdata: rdataMux, readyOut: 1'b1, resp: OKAY};   // no wait states

endmodule

//--- hw/ahbMatrix.sv
`timescale 1ns/10ps

`include "ahbMatrix_config.svh"

module ahbMatrix
    import ahbPkg::*;
    import memMapPkg::*;
(
    input  logic         HCLK,
    input  logic         HRESETn,
    input  ahbAddrPhaseT addrPhase,
    input  dataT         HWDATA,
    output dataT         HRDATA,
    output logic         HREADY,
    output hrespT        HRESP,
    input  gpioInT       ioIn,
    output gpioOutT      ioOut
);

    devSelT  sel;        // address-phase select from the decoder
    ahbRespT ramResp;
    ahbRespT gpioResp;

    // ----------------------------------------
    // decoder, select register, response mux
    // ----------------------------------------
    ahbInterconnect fabric (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .addrPhase (addrPhase),
        .sel       (sel),
        .ramResp   (ramResp),
        .gpioResp  (gpioResp),
        .HREADY    (HREADY),
        .HRDATA    (HRDATA),
        .HRESP     (HRESP)
    );

    // ----------------------------------------
    // subordinates
    // ----------------------------------------

    // on-chip RAM at 0x0000_0000
    ahbRam ram (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .addrPhase (addrPhase),
        .sel       (sel[DEV_RAM]),
        .HREADY    (HREADY),
        .HWDATA    (HWDATA),
        .resp      (ramResp)
    );

    // LEDs, display, switches and buttons at 0x1F80_0000
    ahbGpio gpio (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .addrPhase (addrPhase),
        .sel       (sel[DEV_GPIO]),
        .HREADY    (HREADY),
        .HWDATA    (HWDATA),
        .ioIn      (ioIn),
        .ioOut     (ioOut),
        .resp      (gpioResp)
    );

endmodule

//--- testbench/ahbMatrix_assertions.sv
`timescale 1ns/10ps

module ahbMatrix_assertions
    import ahbPkg::*;
    import memMapPkg::*;
(
    input logic   HCLK,
    input logic   HRESETn,
    input devSelT dataSel,
    input logic   HREADY,
    input hrespT  HRESP
);

    int failCount = 0;   // number of failed assertions

    // at most one subordinate owns the data phase
    selOneHot: assert property (@(posedge HCLK) disable iff (!HRESETn) $onehot0(dataSel))
        else begin
            failCount++;
            $error("data-phase select %b is not one-hot or zero", dataSel);
        end

    respOkay: assert property (@(posedge HCLK) disable iff (!HRESETn) HRESP != ERROR)
        else begin
            failCount++;
            $error("HRESP is ERROR");
        end

    // the RAM read wait is the only stall and lasts one cycle
    readyWait: assert property (@(posedge HCLK) disable iff (!HRESETn) !HREADY |=> HREADY)
        else begin
            failCount++;
            $error("HREADY low for two cycles in a row");
        end

endmodule

//--- testbench/ahbBusTasks.svh
`ifndef AHB_BUS_TASKS_SVH
`define AHB_BUS_TASKS_SVH

    typedef struct {
        addrT  addr;
        hsizeT size;
        logic  write;
        dataT  data;    // write data, or expected read data
    } xferT;

    xferT xfers [$];
    dataT ramModel [1 << `RAM_ADDR_WIDTH];   // reference copy of the RAM array

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task automatic checkWord(input string name, input dataT expVal, input dataT actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("ERR %0t %s expected %h got %h", $time, name, expVal, actVal));
        end
    endtask

    task automatic checkGpioOut(input string name, input gpioOutT expVal, input gpioOutT actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("ERR %0t %s expected %h got %h", $time, name, expVal, actVal));
        end
    endtask

    task automatic checkResp(input string name, input hrespT expVal, input hrespT actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("ERR %0t %s expected %b got %b", $time, name, expVal, actVal));
        end
    endtask

    task automatic checkBit(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("ERR %0t %s expected %b got %b", $time, name, expVal, actVal));
        end
    endtask

    // ----------------------------------------
    // transfer queue
    // ----------------------------------------
    function automatic int ramIdx(input addrT a);
        return int'(a[`RAM_ADDR_WIDTH+1:2]);   // upper bits alias
    endfunction

    // lanes covered by a transfer, lane 0 holds the lowest address
    function automatic logic [3:0] laneEnables(input hsizeT size, input logic [1:0] ofs);
        logic [3:0] en;
        for (int lane = 0; lane < 4; lane++) begin
            en[lane] = (lane >= ofs) && (lane < ofs + (1 << size));
        end
        return en;
    endfunction

    task automatic queueWrite(input addrT a, input hsizeT s, input dataT d);
        xfers.push_back('{addr: a, size: s, write: 1'b1, data: d});
    endtask

    task automatic queueRead(input addrT a, input dataT expVal);
        xfers.push_back('{addr: a, size: WORD, write: 1'b0, data: expVal});
    endtask

    // RAM write that also updates the reference copy
    task automatic ramStore(input addrT a, input hsizeT s, input dataT d);
        logic [3:0] en;
        en = laneEnables(s, a[1:0]);
        for (int lane = 0; lane < 4; lane++) begin
            if (en[lane]) begin
                ramModel[ramIdx(a)][lane*8 +: 8] = d[lane*8 +: 8];
            end
        end
        queueWrite(a, s, d);
    endtask

    // returns on the edge that ends the current data phase
    task automatic waitReady();
        do begin
            @(posedge HCLK);
        end while (HREADY !== 1'b1);
    endtask

    task automatic idleCycles(input int n);
        repeat (n) @(posedge HCLK);
        #DRIVE_DLY;
    endtask

    // pipelined: address phase i goes out with the data phase of i-1
    task automatic runTransfers();
        for (int i = 0; i <= xfers.size(); i++) begin
            if (i < xfers.size()) begin
                addrPhase = '{addr: xfers[i].addr, trans: NONSEQ,
                              size: xfers[i].size, write: xfers[i].write};
            end else begin
                addrPhase.trans = IDLE;
            end
            HWDATA = (i > 0 && xfers[i-1].write) ? xfers[i-1].data : '0;
            waitReady();
            if (i > 0) begin
                checkResp("HRESP", OKAY, HRESP);
                if (!xfers[i-1].write) begin
                    checkWord($sformatf("HRDATA@%h", xfers[i-1].addr), xfers[i-1].data, HRDATA);
                end
            end
            #DRIVE_DLY;
        end
        xfers.delete();
    endtask

`endif

//--- testbench/tbAhbMatrix.sv
`timescale 1ns/10ps

`include "ahbMatrix_config.svh"

module tbAhbMatrix
    import ahbPkg::*;
    import memMapPkg::*;
();

    localparam int   DRIVE_DLY      = 10;     // ns after the rising edge
    localparam int   TIMEOUT_CYCLES = 2000;   // tests run under 200 cycles
    localparam addrT GPIO_BASE      = 32'h1f80_0000;
    localparam addrT NOWHERE        = 32'h1000_0000;   // outside both windows

    logic         HCLK;
    logic         HRESETn;
    ahbAddrPhaseT addrPhase;
    dataT         HWDATA;
    dataT         HRDATA;
    logic         HREADY;
    hrespT        HRESP;
    gpioInT       ioIn;
    gpioOutT      ioOut;

    logic [31:0]  lfsrState  = 32'h502f_1598;
    gpioOutT      gpioModel  = '0;
    int           cycleCount = 0;

    ahbMatrix DUT (.*);

    bind ahbInterconnect ahbMatrix_assertions chk (.HCLK, .HRESETn, .dataSel, .HREADY, .HRESP);

    initial begin
        HCLK = 1'b0;
        forever #50 HCLK = ~HCLK;
    end

    always @(posedge HCLK) begin
        cycleCount++;
        if (DUT.fabric.chk.failCount != 0) begin
            failRun("a bus assertion on the interconnect failed");
        end else if (cycleCount >= TIMEOUT_CYCLES) begin
            failRun($sformatf("timeout: tests still running after %0d cycles", cycleCount));
        end
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // Galois LFSR on x^32 + x^22 + x^2 + x + 1, stepped once per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'h8020_0003 : lfsrState >> 1;
            r = {r[30:0], lfsrState[0]};
        end
        return r;
    endfunction

    function automatic addrT gpioAddr(input logic [GPIO_REG_W-1:0] ofs);
        return GPIO_BASE | (addrT'(ofs) << 2);
    endfunction

`include "ahbBusTasks.svh"

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic resetState();
        checkBit("HREADY", 1'b1, HREADY);
        checkResp("HRESP", OKAY, HRESP);
        checkGpioOut("ioOut", '0, ioOut);
    endtask

    task automatic ramWordTraffic();
        addrT        addrs [16];
        logic [31:0] r;
        for (int i = 0; i < 16; i++) begin
            r = randBits(24);
            addrs[i] = {6'b0, r[23:0], 2'b00};   // bits above the array alias
            ramStore(addrs[i], WORD, randBits(32));
        end
        for (int i = 0; i < 16; i++) begin
            queueRead(addrs[i], ramModel[ramIdx(addrs[i])]);
        end
        runTransfers();
    endtask

    task automatic writeThenReadWord(input addrT a, input hsizeT s);
        ramStore(a, s, randBits(32));   // lanes outside the mask carry noise
        queueRead({a[31:2], 2'b00}, ramModel[ramIdx(a)]);
    endtask

    task automatic ramByteLanes();
        ramStore(32'h0000_0100, WORD, 32'h1122_3344);
        writeThenReadWord(32'h0000_0101, BYTE);
        writeThenReadWord(32'h0000_0102, HALF);
        writeThenReadWord(32'h0000_0103, BYTE);
        writeThenReadWord(32'h0000_0100, HALF);
        runTransfers();
    endtask

    task automatic ledAndHexWrites();
        dataT    red;
        dataT    green;
        dataT    hex;
        gpioOutT expOut;
        red   = randBits(32);
        green = randBits(32);
        hex   = randBits(32);
        expOut.redLeds   = red[`GPIO_N_RED_LEDS-1:0];
        expOut.greenLeds = green[`GPIO_N_GREEN_LEDS-1:0];
        expOut.hex       = hex[`GPIO_HEX_WIDTH-1:0];
        queueWrite(gpioAddr(REG_RED), WORD, red);
        queueWrite(gpioAddr(REG_GREEN), WORD, green);
        queueWrite(gpioAddr(REG_HEX), WORD, hex);
        queueRead(gpioAddr(REG_RED), dataT'(expOut.redLeds));
        queueRead(gpioAddr(REG_GREEN), dataT'(expOut.greenLeds));
        queueRead(gpioAddr(REG_HEX), dataT'(expOut.hex));
        runTransfers();
        checkGpioOut("ioOut", expOut, ioOut);
        gpioModel = expOut;
    endtask

    task automatic switchAndButtonReads();
        logic [31:0] r;
        gpioInT      pins;
        r    = randBits($bits(gpioInT));
        pins = r[$bits(gpioInT)-1:0];
        ioIn = pins;
        idleCycles(3);   // through both synchroniser flops
        queueRead(gpioAddr(REG_SWITCHES), dataT'(pins.switches));
        queueRead(gpioAddr(REG_BUTTONS), dataT'(pins.buttons));
        queueWrite(gpioAddr(REG_SWITCHES), WORD, randBits(32));
        queueWrite(gpioAddr(REG_BUTTONS), WORD, randBits(32));
        queueRead(gpioAddr(REG_SWITCHES), dataT'(pins.switches));
        queueRead(gpioAddr(REG_BUTTONS), dataT'(pins.buttons));
        queueRead(gpioAddr(3'd5), '0);   // unknown offset
        runTransfers();
        checkGpioOut("ioOut", gpioModel, ioOut);
    endtask

    task automatic unmappedAccess();
        queueRead(NOWHERE, '0);
        queueWrite(NOWHERE, WORD, randBits(32));            // would hit REG_RED
        queueWrite(NOWHERE + 32'h100, WORD, randBits(32));  // would hit the lane word
        queueRead(NOWHERE, '0);
        queueRead(32'h0000_0100, ramModel[ramIdx(32'h0000_0100)]);
        queueRead(gpioAddr(REG_RED), dataT'(gpioModel.redLeds));
        runTransfers();
        checkGpioOut("ioOut", gpioModel, ioOut);
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        HRESETn   = 1'b0;
        addrPhase = '{addr: '0, trans: IDLE, size: WORD, write: 1'b0};
        HWDATA    = '0;
        ioIn      = '0;
        repeat (3) @(posedge HCLK);
        #DRIVE_DLY;
        HRESETn = 1'b1;

        resetState();
        ramWordTraffic();
        ramByteLanes();
        ledAndHexWrites();
        switchAndButtonReads();
        unmappedAccess();

        if (DUT.fabric.chk.failCount == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            failRun("a bus assertion on the interconnect failed");
        end
    end

endmodule

//--- ahbMatrix.f
+incdir+hw
+incdir+testbench
hw/ahbPkg.sv
hw/memMapPkg.sv
hw/ahbSlavePort.sv
hw/ahbInterconnect.sv
hw/ahbRam.sv
hw/ahbGpio.sv
hw/ahbMatrix.sv
testbench/ahbMatrix_assertions.sv
testbench/tbAhbMatrix.sv
